// ==== source/routerPkg.sv ====
`default_nettype none

package routerPkg;

  // link and flit geometry.
  localparam int portCount = 5;
  localparam int flitIdWidth = 3;
  localparam int dataWidth = 16;
  localparam int lengthWidth = 12;
  localparam int portIndexWidth = 3;

  // flit identifier codes carried on the flitId field.
  localparam logic [flitIdWidth-1:0] headerFlitId = 3'd1;
  localparam logic [flitIdWidth-1:0] bodyFlitId = 3'd2;

  // Input port indices, also the round-robin rotation order and the output source tag.
  localparam logic [portIndexWidth-1:0] localPort = 3'd0;
  localparam logic [portIndexWidth-1:0] northPort = 3'd1;
  localparam logic [portIndexWidth-1:0] eastPort = 3'd2;
  localparam logic [portIndexWidth-1:0] westPort = 3'd3;
  localparam logic [portIndexWidth-1:0] southPort = 3'd4;

endpackage

`default_nettype wire

// ==== source/inputChannel.sv ====
`default_nettype none

module inputChannel
  import routerPkg::*;
(
  input wire clk,
  input wire rst,
  input wire inReq,
  input wire [flitIdWidth-1:0] inFlitId,
  input wire [dataWidth-1:0] inData,
  input wire slotFree,
  output logic inAck,
  output logic slotValid,
  output logic [flitIdWidth-1:0] slotFlitId,
  output logic [dataWidth-1:0] slotData,
  output logic headerValid,
  output logic [lengthWidth-1:0] headerLength
);

  logic capture;

  // a new flit is taken only with the slot empty and the previous handshake closed.
  assign capture = inReq && !inAck && !slotValid;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inAck <= 1'b0;
      slotValid <= 1'b0;
    end
    else
    begin
      if (capture)
      begin
        inAck <= 1'b1;
        slotValid <= 1'b1;
      end
      else
      begin
        if (inAck && !inReq)
        begin
          inAck <= 1'b0; // source has withdrawn req, close the handshake.
        end
        if (slotFree)
        begin
          slotValid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      slotFlitId <= inFlitId;
      slotData <= inData;
    end
  end

  assign headerValid = slotValid && (slotFlitId == headerFlitId);
  assign headerLength = slotData[lengthWidth-1:0]; // body flit count sits in the low bits.

endmodule

`default_nettype wire

// ==== source/packetTimer.sv ====
`default_nettype none

module packetTimer
  import routerPkg::*;
(
  input wire clk,
  input wire rst,
  input wire load,
  input wire [lengthWidth-1:0] loadLength,
  input wire step,
  output logic expired
);

  logic [lengthWidth-1:0] packetLength;
  logic [lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      packetLength <= '0;
      count <= '0;
    end
    else if (load)
    begin
      packetLength <= loadLength;
      count <= '0;
    end
    else if (step)
    begin
      count <= count + 1'b1; // one more body flit has left.
    end
  end

  // a zero-length packet is already expired right after the load.
  assign expired = (count == packetLength);

endmodule

`default_nettype wire

// ==== source/portArbiter.sv ====
`default_nettype none

module portArbiter
  import routerPkg::*;
(
  input wire clk,
  input wire rst,
  input wire [portCount-1:0] headerValid,
  input wire [lengthWidth-1:0] headerLength [portCount],
  input wire forwarded,
  output logic [portCount-1:0] grant
);

  logic [portIndexWidth-1:0] lastOwner;
  logic headerSent;
  logic pickValid;
  logic [portIndexWidth-1:0] pickIndex;
  logic [portIndexWidth-1:0] candidate;
  logic [portCount-1:0] timerLoad;
  logic [portCount-1:0] timerStep;
  logic [portCount-1:0] expired;
  logic idle;
  logic packetDone;

  assign idle = (grant == '0);

  // Rotation search starting at the port after the last owner.
  always_comb
  begin
    pickValid = 1'b0;
    pickIndex = lastOwner;
    candidate = lastOwner;
    for (int offset = 1; offset <= portCount; offset++)
    begin
      candidate = portIndexWidth'((int'(lastOwner) + offset) % portCount);
      if (!pickValid && headerValid[candidate])
      begin
        pickValid = 1'b1;
        pickIndex = candidate;
      end
    end
  end

  // the slot is still full during the forwarded pulse, so headerValid tells header from body.
  generate
    for (genvar i = 0; i < portCount; i++)
    begin : timerGen
      assign timerLoad[i] = forwarded && grant[i] && headerValid[i];
      assign timerStep[i] = forwarded && grant[i] && !headerValid[i];

      packetTimer packetTimer_i (
        .clk(clk),
        .rst(rst),
        .load(timerLoad[i]),
        .loadLength(headerLength[i]),
        .step(timerStep[i]),
        .expired(expired[i])
      );
    end
  endgenerate

  // the owner's timer is only trusted once its header has loaded it.
  assign packetDone = headerSent && !forwarded && expired[lastOwner];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= '0;
      lastOwner <= southPort; // makes the first search begin at the local port.
      headerSent <= 1'b0;
    end
    else if (idle)
    begin
      if (pickValid)
      begin
        grant <= {{(portCount-1){1'b0}}, 1'b1} << pickIndex;
        lastOwner <= pickIndex;
        headerSent <= 1'b0;
      end
    end
    else
    begin
      if (forwarded)
      begin
        headerSent <= 1'b1;
      end
      else if (packetDone)
      begin
        grant <= '0; // whole packet is out, free the output.
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/outputChannel.sv ====
`default_nettype none

module outputChannel
  import routerPkg::*;
(
  input wire clk,
  input wire rst,
  input wire [portCount-1:0] grant,
  input wire [portCount-1:0] slotValid,
  input wire [flitIdWidth-1:0] slotFlitId [portCount],
  input wire [dataWidth-1:0] slotData [portCount],
  input wire outAck,
  output logic outReq,
  output logic [flitIdWidth-1:0] outFlitId,
  output logic [dataWidth-1:0] outData,
  output logic [portIndexWidth-1:0] outSource,
  output logic forwarded,
  output logic [portCount-1:0] slotFree
);

  logic selValid;
  logic [portIndexWidth-1:0] selIndex;
  logic [flitIdWidth-1:0] selFlitId;
  logic [dataWidth-1:0] selData;
  logic launch;

  always_comb
  begin
    selValid = 1'b0;
    selIndex = '0;
    selFlitId = '0;
    selData = '0;
    for (int i = 0; i < portCount; i++)
    begin
      if (grant[i])
      begin
        selValid = slotValid[i];
        selIndex = portIndexWidth'(i);
        selFlitId = slotFlitId[i];
        selData = slotData[i];
      end
    end
  end

  // while forwarded is high the sent flit is still in its slot and must not go twice.
  assign launch = !outReq && !forwarded && selValid && !outAck;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outReq <= 1'b0;
      forwarded <= 1'b0;
      slotFree <= '0;
    end
    else
    begin
      forwarded <= 1'b0;
      slotFree <= '0;
      if (launch)
      begin
        outReq <= 1'b1;
      end
      else if (outReq && outAck)
      begin
        outReq <= 1'b0;
        forwarded <= 1'b1;
        slotFree <= grant; // grant cannot move while the flit is in flight.
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (launch)
    begin
      outFlitId <= selFlitId;
      outData <= selData;
      outSource <= selIndex;
    end
  end

endmodule

`default_nettype wire

// ==== source/routerOutputPort.sv ====
`default_nettype none

module routerOutputPort
  import routerPkg::*;
(
  input wire clk,
  input wire rst,
  input wire [portCount-1:0] inReq,
  input wire [flitIdWidth-1:0] inFlitId [portCount],
  input wire [dataWidth-1:0] inData [portCount],
  input wire outAck,
  output logic [portCount-1:0] inAck,
  output logic outReq,
  output logic [flitIdWidth-1:0] outFlitId,
  output logic [dataWidth-1:0] outData,
  output logic [portIndexWidth-1:0] outSource
);

  logic [portCount-1:0] slotValid;
  logic [flitIdWidth-1:0] slotFlitId [portCount];
  logic [dataWidth-1:0] slotData [portCount];
  logic [portCount-1:0] headerValid;
  logic [lengthWidth-1:0] headerLength [portCount];
  logic [portCount-1:0] slotFree;
  logic [portCount-1:0] grant;
  logic forwarded;

  generate
    for (genvar i = 0; i < portCount; i++)
    begin : inputGen
      inputChannel inputChannel_i (
        .clk(clk),
        .rst(rst),
        .inReq(inReq[i]),
        .inFlitId(inFlitId[i]),
        .inData(inData[i]),
        .slotFree(slotFree[i]),
        .inAck(inAck[i]),
        .slotValid(slotValid[i]),
        .slotFlitId(slotFlitId[i]),
        .slotData(slotData[i]),
        .headerValid(headerValid[i]),
        .headerLength(headerLength[i])
      );
    end
  endgenerate

  portArbiter portArbiter_i (
    .clk(clk),
    .rst(rst),
    .headerValid(headerValid),
    .headerLength(headerLength),
    .forwarded(forwarded),
    .grant(grant)
  );

  outputChannel outputChannel_i (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .slotValid(slotValid),
    .slotFlitId(slotFlitId),
    .slotData(slotData),
    .outAck(outAck),
    .outReq(outReq),
    .outFlitId(outFlitId),
    .outData(outData),
    .outSource(outSource),
    .forwarded(forwarded),
    .slotFree(slotFree)
  );

endmodule

`default_nettype wire

// ==== tests/routerChecker.sv ====
`default_nettype none

module routerChecker
  import routerPkg::*;
(
  input wire clk,
  input wire rst,
  input wire [portCount-1:0] inAck,
  input wire [flitIdWidth-1:0] inFlitId [portCount],
  input wire [dataWidth-1:0] inData [portCount],
  input wire outReq,
  input wire outAck,
  input wire [flitIdWidth-1:0] outFlitId,
  input wire [dataWidth-1:0] outData,
  input wire [portIndexWidth-1:0] outSource,
  input wire rrPhase,
  input wire done,
  output int errorCount,
  output int outFlits
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int flitWidth = flitIdWidth + dataWidth;
  localparam int fieldWidth = flitWidth + portIndexWidth;

  logic [flitWidth-1:0] expectQ [portCount][$];
  int ackCount [portCount];
  int fwdCount [portCount];
  logic [portCount-1:0] prevAck = '0;
  logic prevReq = 1'b0;
  logic prevOutAck = 1'b0;
  logic prevRst = 1'b1;
  logic [fieldWidth-1:0] prevFields = '0;
  logic inPacket = 1'b0;
  logic [portIndexWidth-1:0] curSource = '0;
  logic [portIndexWidth-1:0] lastHeader = southPort; // arbiter starts its search at local.
  logic [lengthWidth-1:0] remaining = '0;
  logic reported = 1'b0;
  int resetErrors = 0;
  int dataErrors = 0;
  int packetErrors = 0;
  int protocolErrors = 0;
  int rotationErrors = 0;
  int pressureErrors = 0;

  assign errorCount = resetErrors + dataErrors + packetErrors + protocolErrors
                      + rotationErrors + pressureErrors;

  initial
  begin
    outFlits = 0;
    for (int i = 0; i < portCount; i++)
    begin
      ackCount[i] = 0;
      fwdCount[i] = 0;
    end
  end

  always @(posedge clk)
  begin : watch
    logic [flitWidth-1:0] expected;
    logic [fieldWidth-1:0] fields;
    int src;
    fields = {outFlitId, outData, outSource};
    src = int'(outSource);
    if ((rst || prevRst) && (outReq || inAck != '0))
    begin
      resetErrors++;
      $display("Error at %0t: outReq or inAck high around reset", $time);
    end
    if (!rst)
    begin
      for (int i = 0; i < portCount; i++)
      begin
        if (inAck[i] && !prevAck[i])
        begin
          expectQ[i].push_back({inFlitId[i], inData[i]}); // fields still held by the source.
          ackCount[i]++;
        end
      end
      if (outReq && !prevReq && prevOutAck)
      begin
        protocolErrors++;
        $display("Error at %0t: outReq rose while outAck was high", $time);
      end
      if (!outReq && prevReq && !prevOutAck)
      begin
        protocolErrors++;
        $display("Error at %0t: outReq fell before outAck was seen", $time);
      end
      if (outReq && prevReq && fields != prevFields)
      begin
        protocolErrors++;
        $display("Error at %0t: output fields changed while outReq high", $time);
      end
      if (outReq && outAck)
      begin
        outFlits++;
        if (src >= portCount || expectQ[src].size() == 0)
        begin
          dataErrors++;
          $display("Error at %0t: unexpected flit from source %0d", $time, src);
        end
        else
        begin
          expected = expectQ[src].pop_front();
          fwdCount[src]++;
          if (expected != {outFlitId, outData})
          begin
            dataErrors++;
            $display("Error at %0t: source %0d sent %h, expected %h", $time, src,
                     {outFlitId, outData}, expected);
          end
        end
        if (inPacket)
        begin
          if (outSource != curSource || outFlitId != bodyFlitId)
          begin
            packetErrors++;
            $display("Error at %0t: packet from %0d broken by source %0d", $time,
                     curSource, src);
          end
          remaining = remaining - 1'b1;
          inPacket = (remaining != '0);
        end
        else if (outFlitId != headerFlitId)
        begin
          packetErrors++;
          $display("Error at %0t: flit outside a packet is not a header", $time);
        end
        else
        begin
          if (rrPhase && int'(outSource) != (int'(lastHeader) + 1) % portCount)
          begin
            rotationErrors++;
            $display("Error at %0t: header from %0d after %0d breaks rotation", $time,
                     src, lastHeader);
          end
          lastHeader = outSource;
          curSource = outSource;
          remaining = outData[lengthWidth-1:0];
          inPacket = (remaining != '0);
        end
      end
      for (int i = 0; i < portCount; i++)
      begin
        if (ackCount[i] > fwdCount[i] + 1)
        begin
          pressureErrors++;
          $display("Error at %0t: port %0d acked a flit into a full slot", $time, i);
        end
      end
    end
    prevAck = inAck;
    prevReq = outReq;
    prevOutAck = outAck;
    prevRst = rst;
    prevFields = fields;
    if (done && !reported)
    begin
      reported = 1'b1;
      for (int i = 0; i < portCount; i++)
      begin
        if (expectQ[i].size() != 0)
        begin
          dataErrors++;
          $display("Error at %0t: %0d flits of port %0d never left", $time,
                   expectQ[i].size(), i);
        end
      end
      $display("errors: reset %0d, data %0d, packet %0d, protocol %0d, rotation %0d, %s %0d",
               resetErrors, dataErrors, packetErrors, protocolErrors, rotationErrors,
               "back-pressure", pressureErrors);
    end
  end

endmodule

`default_nettype wire

// ==== tests/routerOutputPortTb.sv ====
`default_nettype none

module routerOutputPortTb
  import routerPkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int randomPackets = 20;
  localparam int rrPackets = 3;
  localparam int maxBody = 6;
  localparam int flitBound = (randomPackets + rrPackets) * portCount * (maxBody + 1);
  localparam int cycleLimit = 200 * flitBound;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic [portCount-1:0] inReq;
  logic [flitIdWidth-1:0] inFlitId [portCount];
  logic [dataWidth-1:0] inData [portCount];
  logic outAck;
  wire [portCount-1:0] inAck;
  wire outReq;
  wire [flitIdWidth-1:0] outFlitId;
  wire [dataWidth-1:0] outData;
  wire [portIndexWidth-1:0] outSource;
  logic rrPhase;
  logic done;
  int errorCount;
  int outFlits;
  int sentFlits = 0;
  int cycleCount = 0;
  integer seed = 32'h626c_7ba8;

  always #5 clk = ~clk;

  routerOutputPort routerOutputPort_i (
    .clk(clk),
    .rst(rst),
    .inReq(inReq),
    .inFlitId(inFlitId),
    .inData(inData),
    .outAck(outAck),
    .inAck(inAck),
    .outReq(outReq),
    .outFlitId(outFlitId),
    .outData(outData),
    .outSource(outSource)
  );

  routerChecker routerChecker_i (
    .clk(clk),
    .rst(rst),
    .inAck(inAck),
    .inFlitId(inFlitId),
    .inData(inData),
    .outReq(outReq),
    .outAck(outAck),
    .outFlitId(outFlitId),
    .outData(outData),
    .outSource(outSource),
    .rrPhase(rrPhase),
    .done(done),
    .errorCount(errorCount),
    .outFlits(outFlits)
  );

  function automatic int randBelow(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // one full four-phase handshake on input link p.
  task automatic sendFlit(input int p, input logic [flitIdWidth-1:0] id,
                          input logic [dataWidth-1:0] word);
    @(negedge clk);
    inFlitId[p] = id;
    inData[p] = word;
    inReq[p] = 1'b1;
    while (!inAck[p])
      @(negedge clk);
    inReq[p] = 1'b0;
    while (inAck[p])
      @(negedge clk);
    sentFlits++;
  endtask

  task automatic sendPackets(input int p, input int count, input bit gaps);
    int length;
    logic [dataWidth-1:0] word;
    for (int k = 0; k < count; k++)
    begin
      length = randBelow(maxBody + 1);
      word = dataWidth'(randBelow(65536));
      word[lengthWidth-1:0] = lengthWidth'(length); // upper bits stay random.
      sendFlit(p, headerFlitId, word);
      for (int b = 0; b < length; b++)
      begin
        if (gaps)
          repeat (randBelow(4)) @(negedge clk);
        sendFlit(p, bodyFlitId, dataWidth'(randBelow(65536)));
      end
      if (gaps)
        repeat (randBelow(4)) @(negedge clk);
    end
  endtask

  task automatic runAllSources(input int count, input bit gaps);
    fork
      sendPackets(0, count, gaps);
      sendPackets(1, count, gaps);
      sendPackets(2, count, gaps);
      sendPackets(3, count, gaps);
      sendPackets(4, count, gaps);
    join
  endtask

  task automatic waitDrained();
    while (outFlits != sentFlits)
      @(negedge clk);
  endtask

  // the sink acks each request after 0 to 3 cycles and keeps ack up to 3 cycles past req.
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (outReq && !outAck)
      begin
        repeat (randBelow(4)) @(negedge clk);
        outAck = 1'b1;
      end
      else if (!outReq && outAck)
      begin
        repeat (randBelow(4)) @(negedge clk);
        outAck = 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= cycleLimit)
    begin
      $display("the run hit its limit of %0d cycles before all flits came out", cycleLimit);
      $display("test failed");
      $finish;
    end
  end

  initial
  begin
    inReq = '0;
    outAck = 1'b0;
    rrPhase = 1'b0;
    done = 1'b0;
    for (int i = 0; i < portCount; i++)
    begin
      inFlitId[i] = '0;
      inData[i] = '0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    runAllSources(randomPackets, 1'b1);
    waitDrained();
    rrPhase = 1'b1; // every port now queues back-to-back packets.
    runAllSources(rrPackets, 1'b0);
    waitDrained();
    repeat (4) @(negedge clk);
    done = 1'b1;
    repeat (2) @(negedge clk);
    if (errorCount == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
source/routerPkg.sv
source/inputChannel.sv
source/packetTimer.sv
source/portArbiter.sv
source/outputChannel.sv
source/routerOutputPort.sv
tests/routerChecker.sv
tests/routerOutputPortTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the router output port testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module routerOutputPortTb \
  --Mdir obj_dir -o routerSim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/routerSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi

if ! grep -q "test passed" sim.log; then
  echo "simulation log has no result line"
  exit 1
fi

exit 0
